// File: design/tx_queue_pkg.sv
// ##########################################################################
// Transmit queue organization shared by the DMA intake and its testbench
// ##########################################################################

package tx_queue_pkg;

	// Four hardware transmit queues, one per access category
	localparam int NUM_TX_QUEUE = 4;

	localparam int TX_QUEUE_IDX_WIDTH = $clog2(NUM_TX_QUEUE); // Two bits

endpackage

// File: design/tx_dma_pkg.sv
// ##########################################################################
// DMA stream description: symbol width, queue depth and intake burst state
// ##########################################################################

package tx_dma_pkg;

	localparam int DEFAULT_TDATA_WIDTH = 64; // One DMA symbol per beat

	// Queue depth in symbols, must be a power of two
	localparam int DEFAULT_MAX_NUM_DMA_SYMBOL = 8192;

	// Intake state, also visible on s_axis_recv_data_from_high
	typedef enum logic
	{
		TX_BURST_IDLE  = 1'b0,
		TX_BURST_WRITE = 1'b1
	} tx_burst_state_t;

endpackage

// File: design/tx_queue_fifo.sv
// ##########################################################################
// Synchronous first-word-fall-through FIFO for one transmit queue
// ##########################################################################

`timescale 1ns/1ps

module tx_queue_fifo
	import tx_dma_pkg::*;
#(
	parameter integer C_S_AXIS_TDATA_WIDTH = DEFAULT_TDATA_WIDTH,
	parameter integer MAX_NUM_DMA_SYMBOL   = DEFAULT_MAX_NUM_DMA_SYMBOL,
	localparam integer ADDR_WIDTH = $clog2(MAX_NUM_DMA_SYMBOL),
	localparam integer CNT_WIDTH  = ADDR_WIDTH + 1
)
(
	input  logic                            S_AXIS_ACLK,
	input  logic                            S_AXIS_ARESETN,
	input  logic                            wr_en,
	input  logic [C_S_AXIS_TDATA_WIDTH-1:0] din,
	input  logic                            rd_en,
	output logic [C_S_AXIS_TDATA_WIDTH-1:0] dout,
	output logic                            empty,
	output logic                            full,
	output logic [CNT_WIDTH-1:0]            data_count
);

	logic [C_S_AXIS_TDATA_WIDTH-1:0] mem [MAX_NUM_DMA_SYMBOL];

	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0]  count;

	// Head word is presented without a read cycle
	assign dout       = mem[rd_ptr];
	assign empty      = (count == '0);
	assign full       = (count == CNT_WIDTH'(MAX_NUM_DMA_SYMBOL));
	assign data_count = count;

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= din;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
			end
			if (rd_en)
			begin
				rd_ptr <= rd_ptr + ADDR_WIDTH'(1);
			end
		end
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			count <= '0;
		end
		else if (wr_en && !rd_en)
		begin
			count <= count + CNT_WIDTH'(1);
		end
		else if (rd_en && !wr_en)
		begin
			count <= count - CNT_WIDTH'(1);
		end
	end

	// Parent holds tready low on a full queue
	a_no_write_when_full: assert property (
		@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(wr_en && full)
	) else $error("Write into full queue");

	// Parent gates the accelerator ask with not-empty
	a_no_read_when_empty: assert property (
		@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(rd_en && empty)
	) else $error("Read from empty queue");

endmodule

// File: design/tx_intf_s_axis.sv
// ##########################################################################
// AXI-Stream intake that steers DMA bursts into four transmit queues and
// serves the accelerator from the queue it selects
// ##########################################################################

`timescale 1ns/1ps

module tx_intf_s_axis
	import tx_queue_pkg::*;
	import tx_dma_pkg::*;
#(
	parameter integer C_S_AXIS_TDATA_WIDTH = DEFAULT_TDATA_WIDTH,
	parameter integer MAX_NUM_DMA_SYMBOL   = DEFAULT_MAX_NUM_DMA_SYMBOL,
	localparam integer CNT_WIDTH = $clog2(MAX_NUM_DMA_SYMBOL) + 1
)
(
	input  logic                            S_AXIS_ACLK,
	input  logic                            S_AXIS_ARESETN,

	input  logic [TX_QUEUE_IDX_WIDTH-1:0]   wr_queue_idx,   // Queue for the current burst
	input  logic [TX_QUEUE_IDX_WIDTH-1:0]   rd_queue_idx,   // Queue the accelerator reads
	input  logic                            endless_mode,
	input  logic [CNT_WIDTH-1:0]            num_dma_symbol_raw,
	output logic                            s_axis_recv_data_from_high,

	input  logic                            s_axis_tvalid,
	output logic                            s_axis_tready,
	input  logic [C_S_AXIS_TDATA_WIDTH-1:0] s_axis_tdata,
	input  logic                            s_axis_tlast,

	input  logic                            acc_ask_data,
	output logic [C_S_AXIS_TDATA_WIDTH-1:0] data_to_acc,
	output logic                            emptyn_to_acc,
	output logic [CNT_WIDTH-1:0]            data_count0,
	output logic [CNT_WIDTH-1:0]            data_count1,
	output logic [CNT_WIDTH-1:0]            data_count2,
	output logic [CNT_WIDTH-1:0]            data_count3
);

	tx_burst_state_t burst_state;

	logic [CNT_WIDTH-1:0] num_dma_symbol; // Last pointer value of a burst
	logic [CNT_WIDTH-1:0] write_pointer;
	logic                 writes_done;
	logic                 burst_open;
	logic                 beat_accept;

	logic [C_S_AXIS_TDATA_WIDTH-1:0] q_dout [NUM_TX_QUEUE];
	logic [CNT_WIDTH-1:0]            q_count [NUM_TX_QUEUE];
	logic [NUM_TX_QUEUE-1:0]         q_empty;
	logic [NUM_TX_QUEUE-1:0]         q_full;
	logic [NUM_TX_QUEUE-1:0]         q_wren;
	logic [NUM_TX_QUEUE-1:0]         q_rden;

	// Burst accepts beats until done, unless the limit is reached in bounded mode
	assign burst_open = (burst_state == TX_BURST_WRITE) && !writes_done &&
		((write_pointer <= num_dma_symbol) || endless_mode);

	assign s_axis_tready = burst_open && !q_full[wr_queue_idx];
	assign beat_accept   = s_axis_tvalid && s_axis_tready;

	assign s_axis_recv_data_from_high = (burst_state == TX_BURST_WRITE);

	assign data_to_acc   = q_dout[rd_queue_idx];
	assign emptyn_to_acc = !q_empty[rd_queue_idx];

	assign data_count0 = q_count[0];
	assign data_count1 = q_count[1];
	assign data_count2 = q_count[2];
	assign data_count3 = q_count[3];

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			burst_state    <= TX_BURST_IDLE;
			num_dma_symbol <= '0;
		end
		else
		begin
			num_dma_symbol <= num_dma_symbol_raw - CNT_WIDTH'(1); // New length one cycle later
			case (burst_state)
				TX_BURST_IDLE:
				begin
					if (s_axis_tvalid)
					begin
						burst_state <= TX_BURST_WRITE;
					end
				end
				TX_BURST_WRITE:
				begin
					if (writes_done)
					begin
						burst_state <= TX_BURST_IDLE;
					end
				end
				default:
				begin
					burst_state <= TX_BURST_IDLE;
				end
			endcase
		end
	end

	// Burst ends on the Nth beat or on an accepted TLAST
	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			write_pointer <= '0;
			writes_done   <= 1'b0;
		end
		else if (writes_done)
		begin
			write_pointer <= '0;
			writes_done   <= 1'b0;
		end
		else if (beat_accept)
		begin
			write_pointer <= write_pointer + CNT_WIDTH'(1);
			if (((write_pointer == num_dma_symbol) && !endless_mode) || s_axis_tlast)
			begin
				writes_done <= 1'b1;
			end
		end
	end

	for (genvar i = 0; i < NUM_TX_QUEUE; i++)
	begin : g_queue
		assign q_wren[i] = beat_accept && (wr_queue_idx == TX_QUEUE_IDX_WIDTH'(i));
		assign q_rden[i] = acc_ask_data && emptyn_to_acc &&
			(rd_queue_idx == TX_QUEUE_IDX_WIDTH'(i)); // Ask on empty is dropped

		tx_queue_fifo #(
			.C_S_AXIS_TDATA_WIDTH(C_S_AXIS_TDATA_WIDTH),
			.MAX_NUM_DMA_SYMBOL  (MAX_NUM_DMA_SYMBOL)
		) queue_fifo_inst (
			.S_AXIS_ACLK   (S_AXIS_ACLK),
			.S_AXIS_ARESETN(S_AXIS_ARESETN),
			.wr_en         (q_wren[i]),
			.din           (s_axis_tdata),
			.rd_en         (q_rden[i]),
			.dout          (q_dout[i]),
			.empty         (q_empty[i]),
			.full          (q_full[i]),
			.data_count    (q_count[i])
		);
	end

	a_idle_not_ready: assert property (
		@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		(burst_state == TX_BURST_IDLE) |-> !s_axis_tready
	) else $error("tready high while intake idle");

	a_done_to_idle: assert property (
		@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		writes_done |=> (burst_state == TX_BURST_IDLE) && (write_pointer == '0)
	) else $error("Intake did not return to idle after burst end");

endmodule

// File: design/tx_intf.sv
// ##########################################################################
// Top of the transmit DMA intake, sets queue width and depth for the core
// ##########################################################################

`timescale 1ns/1ps

module tx_intf
	import tx_queue_pkg::*;
	import tx_dma_pkg::*;
#(
	parameter integer C_S_AXIS_TDATA_WIDTH = DEFAULT_TDATA_WIDTH,
	parameter integer MAX_NUM_DMA_SYMBOL   = DEFAULT_MAX_NUM_DMA_SYMBOL,
	localparam integer CNT_WIDTH = $clog2(MAX_NUM_DMA_SYMBOL) + 1
)
(
	input  logic                            S_AXIS_ACLK,
	input  logic                            S_AXIS_ARESETN,

	// Processor side
	input  logic [TX_QUEUE_IDX_WIDTH-1:0]   wr_queue_idx,
	input  logic                            endless_mode,
	input  logic [CNT_WIDTH-1:0]            num_dma_symbol_raw,
	output logic                            s_axis_recv_data_from_high,
	input  logic                            s_axis_tvalid,
	output logic                            s_axis_tready,
	input  logic [C_S_AXIS_TDATA_WIDTH-1:0] s_axis_tdata,
	input  logic                            s_axis_tlast,

	// Accelerator side
	input  logic [TX_QUEUE_IDX_WIDTH-1:0]   rd_queue_idx,
	input  logic                            acc_ask_data,
	output logic [C_S_AXIS_TDATA_WIDTH-1:0] data_to_acc,
	output logic                            emptyn_to_acc,
	output logic [CNT_WIDTH-1:0]            data_count0,
	output logic [CNT_WIDTH-1:0]            data_count1,
	output logic [CNT_WIDTH-1:0]            data_count2,
	output logic [CNT_WIDTH-1:0]            data_count3
);

	tx_intf_s_axis #(
		.C_S_AXIS_TDATA_WIDTH(C_S_AXIS_TDATA_WIDTH),
		.MAX_NUM_DMA_SYMBOL  (MAX_NUM_DMA_SYMBOL)
	) tx_intf_s_axis_inst (
		.S_AXIS_ACLK               (S_AXIS_ACLK),
		.S_AXIS_ARESETN            (S_AXIS_ARESETN),
		.wr_queue_idx              (wr_queue_idx),
		.rd_queue_idx              (rd_queue_idx),
		.endless_mode              (endless_mode),
		.num_dma_symbol_raw        (num_dma_symbol_raw),
		.s_axis_recv_data_from_high(s_axis_recv_data_from_high),
		.s_axis_tvalid             (s_axis_tvalid),
		.s_axis_tready             (s_axis_tready),
		.s_axis_tdata              (s_axis_tdata),
		.s_axis_tlast              (s_axis_tlast),
		.acc_ask_data              (acc_ask_data),
		.data_to_acc               (data_to_acc),
		.emptyn_to_acc             (emptyn_to_acc),
		.data_count0               (data_count0),
		.data_count1               (data_count1),
		.data_count2               (data_count2),
		.data_count3               (data_count3)
	);

endmodule

// File: tb/tb_tx_intf.sv
// ##########################################################################
// Testbench for the transmit DMA intake, drives bursts and accelerator reads
// ##########################################################################

`timescale 1ns/1ps

module tb_tx_intf
	import tx_queue_pkg::*;
	import tx_dma_pkg::*;
();

	localparam int DATA_WIDTH = DEFAULT_TDATA_WIDTH;
	localparam int DEPTH      = 16; // Small enough to fill a queue
	localparam int CNT_WIDTH  = $clog2(DEPTH) + 1;
	localparam int CLK_PERIOD = 20;
	localparam int SEED       = 98;

	// Cycle budget per test: reset, steering, length, tlast, endless, read order
	localparam int TEST_CYCLES     = 10 + 130 + 100 + 100 + 130 + 170;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;

	logic                          S_AXIS_ACLK = 1'b0;
	logic                          S_AXIS_ARESETN;
	logic [TX_QUEUE_IDX_WIDTH-1:0] wr_queue_idx;
	logic [TX_QUEUE_IDX_WIDTH-1:0] rd_queue_idx;
	logic                          endless_mode;
	logic [CNT_WIDTH-1:0]          num_dma_symbol_raw;
	logic                          s_axis_recv_data_from_high;
	logic                          s_axis_tvalid;
	logic                          s_axis_tready;
	logic [DATA_WIDTH-1:0]         s_axis_tdata;
	logic                          s_axis_tlast;
	logic                          acc_ask_data;
	logic [DATA_WIDTH-1:0]         data_to_acc;
	logic                          emptyn_to_acc;
	logic [CNT_WIDTH-1:0]          data_count [NUM_TX_QUEUE];

	logic [DATA_WIDTH-1:0] model_q [NUM_TX_QUEUE][$]; // Every accepted beat per queue
	logic [DATA_WIDTH-1:0] model_head [NUM_TX_QUEUE];
	int                    model_cnt [NUM_TX_QUEUE];
	int                    burst_beats = 0; // Accepted in the current burst
	int                    exp_beats = 0;
	logic                  aresetn_d = 1'b0;

	// Bus activity seen mid-cycle, applied to the model at the next edge
	logic                          pend_push = 1'b0;
	logic                          pend_pop = 1'b0;
	logic                          pend_idle = 1'b0;
	logic [DATA_WIDTH-1:0]         pend_data = '0;
	logic [TX_QUEUE_IDX_WIDTH-1:0] pend_widx = '0;
	logic [TX_QUEUE_IDX_WIDTH-1:0] pend_ridx = '0;

	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_with_errors = 0;

	tx_intf #(
		.C_S_AXIS_TDATA_WIDTH(DATA_WIDTH),
		.MAX_NUM_DMA_SYMBOL  (DEPTH)
	) tx_intf_inst (
		.S_AXIS_ACLK               (S_AXIS_ACLK),
		.S_AXIS_ARESETN            (S_AXIS_ARESETN),
		.wr_queue_idx              (wr_queue_idx),
		.endless_mode              (endless_mode),
		.num_dma_symbol_raw        (num_dma_symbol_raw),
		.s_axis_recv_data_from_high(s_axis_recv_data_from_high),
		.s_axis_tvalid             (s_axis_tvalid),
		.s_axis_tready             (s_axis_tready),
		.s_axis_tdata              (s_axis_tdata),
		.s_axis_tlast              (s_axis_tlast),
		.rd_queue_idx              (rd_queue_idx),
		.acc_ask_data              (acc_ask_data),
		.data_to_acc               (data_to_acc),
		.emptyn_to_acc             (emptyn_to_acc),
		.data_count0               (data_count[0]),
		.data_count1               (data_count[1]),
		.data_count2               (data_count[2]),
		.data_count3               (data_count[3])
	);

	always #(CLK_PERIOD / 2) S_AXIS_ACLK = ~S_AXIS_ACLK;

	always @(negedge S_AXIS_ACLK)
	begin
		pend_push = s_axis_tvalid && s_axis_tready;
		pend_pop  = acc_ask_data && (model_cnt[rd_queue_idx] != 0); // Ask on empty is ignored
		pend_idle = !s_axis_recv_data_from_high;
		pend_data = s_axis_tdata;
		pend_widx = wr_queue_idx;
		pend_ridx = rd_queue_idx;
	end

	always @(posedge S_AXIS_ACLK)
	begin
		aresetn_d <= S_AXIS_ARESETN;
		if (!S_AXIS_ARESETN)
		begin
			for (int i = 0; i < NUM_TX_QUEUE; i++)
				model_q[i].delete();
			burst_beats = 0;
		end
		else
		begin
			if (pend_pop)
				void'(model_q[pend_ridx].pop_front());
			if (pend_push)
			begin
				model_q[pend_widx].push_back(pend_data);
				burst_beats++;
			end
			else if (pend_idle)
				burst_beats = 0;
		end
		for (int i = 0; i < NUM_TX_QUEUE; i++)
		begin
			model_cnt[i]  = model_q[i].size();
			model_head[i] = (model_cnt[i] != 0) ? model_q[i][0] : '0;
		end
	end

	// Outputs are compared mid-cycle where they are stable
	a_reset_state: assert property (@(negedge S_AXIS_ACLK)
		(!S_AXIS_ARESETN || !aresetn_d) |->
		!s_axis_tready && !emptyn_to_acc && !s_axis_recv_data_from_high &&
		({data_count[0], data_count[1], data_count[2], data_count[3]} == '0) &&
		(tx_intf_inst.tx_intf_s_axis_inst.burst_state == TX_BURST_IDLE))
	else
	begin
		errors++;
		$display("Mismatch reset state: tready %h emptyn_to_acc %h recv %h counts %h, expected 0",
			s_axis_tready, emptyn_to_acc, s_axis_recv_data_from_high,
			{data_count[0], data_count[1], data_count[2], data_count[3]});
	end

	for (genvar i = 0; i < NUM_TX_QUEUE; i++)
	begin : g_count_check
		a_count: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
			data_count[i] == CNT_WIDTH'(model_cnt[i]))
		else
		begin
			errors++;
			$display("Mismatch data_count%0d: got %h expected %h", i, data_count[i],
				CNT_WIDTH'(model_cnt[i]));
		end
	end

	a_emptyn: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		emptyn_to_acc == (model_cnt[rd_queue_idx] != 0))
	else
	begin
		errors++;
		$display("Mismatch emptyn_to_acc: got %h expected %h", emptyn_to_acc,
			model_cnt[rd_queue_idx] != 0);
	end

	a_head: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		emptyn_to_acc |-> (data_to_acc == model_head[rd_queue_idx]))
	else
	begin
		errors++;
		$display("Mismatch data_to_acc: got %h expected %h", data_to_acc,
			model_head[rd_queue_idx]);
	end

	a_idle_tready: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!s_axis_recv_data_from_high |-> !s_axis_tready)
	else
	begin
		errors++;
		$display("Mismatch s_axis_tready: got %h expected 0 between bursts", s_axis_tready);
	end

	a_full_holds: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		(model_cnt[wr_queue_idx] == DEPTH) |-> !s_axis_tready)
	else
	begin
		errors++;
		$display("Mismatch s_axis_tready: got %h expected 0 on full queue", s_axis_tready);
	end

	a_burst_len: assert property (@(negedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		$fell(s_axis_recv_data_from_high) |-> (burst_beats == exp_beats))
	else
	begin
		errors++;
		$display("Mismatch accepted beats: got %h expected %h", burst_beats, exp_beats);
	end

	// Offers beats until TLAST is taken or, without TLAST, the burst closes
	task automatic send_burst(input int idx, input int len, input bit endless,
		input int tlast_pos, input int expect_beats);
		int sent;
		bit closed;
		bit took;
		sent   = 0;
		closed = 1'b0;
		@(posedge S_AXIS_ACLK);
		wr_queue_idx       <= TX_QUEUE_IDX_WIDTH'(idx);
		num_dma_symbol_raw <= CNT_WIDTH'(len);
		endless_mode       <= endless;
		exp_beats = expect_beats;
		@(posedge S_AXIS_ACLK); // Length register loaded
		s_axis_tvalid <= 1'b1;
		s_axis_tdata  <= {$urandom, $urandom};
		s_axis_tlast  <= (tlast_pos == 1);
		while (!closed)
		begin
			@(negedge S_AXIS_ACLK);
			took = s_axis_tready;
			if (took)
				sent++;
			closed = (tlast_pos != 0) ? (sent == tlast_pos) : (sent > 0 && !took);
			@(posedge S_AXIS_ACLK);
			if (closed)
			begin
				s_axis_tvalid <= 1'b0;
				s_axis_tlast  <= 1'b0;
			end
			else if (took)
			begin
				s_axis_tdata <= {$urandom, $urandom};
				s_axis_tlast <= (sent + 1 == tlast_pos);
			end
		end
		do
			@(negedge S_AXIS_ACLK);
		while (s_axis_recv_data_from_high);
	endtask

	task automatic hold_full_and_pop(input int idx, input int beats_now);
		do
			@(negedge S_AXIS_ACLK);
		while (data_count[idx] != CNT_WIDTH'(DEPTH));
		repeat (4) @(negedge S_AXIS_ACLK);
		assert (burst_beats == beats_now && s_axis_tvalid && !s_axis_tready)
		else
		begin
			errors++;
			$display("Mismatch beats on full queue: got %h expected %h, tready %h",
				burst_beats, beats_now, s_axis_tready);
		end
		@(posedge S_AXIS_ACLK);
		rd_queue_idx <= TX_QUEUE_IDX_WIDTH'(idx);
		acc_ask_data <= 1'b1;
		@(posedge S_AXIS_ACLK);
		acc_ask_data <= 1'b0;
	endtask

	task automatic random_reads(input int cycles);
		repeat (cycles)
		begin
			@(posedge S_AXIS_ACLK);
			rd_queue_idx <= TX_QUEUE_IDX_WIDTH'($urandom_range(NUM_TX_QUEUE - 1));
			acc_ask_data <= 1'($urandom_range(1));
		end
		@(posedge S_AXIS_ACLK);
		acc_ask_data <= 1'b0;
	endtask

	// Asks one more time than a queue can hold, the last asks hit empty
	task automatic drain_queues();
		for (int q = 0; q < NUM_TX_QUEUE; q++)
		begin
			@(posedge S_AXIS_ACLK);
			rd_queue_idx <= TX_QUEUE_IDX_WIDTH'(q);
			acc_ask_data <= 1'b1;
			repeat (DEPTH) @(posedge S_AXIS_ACLK);
		end
		@(posedge S_AXIS_ACLK);
		acc_ask_data <= 1'b0;
	endtask

	task automatic report_test(input string name);
		repeat (2) @(negedge S_AXIS_ACLK);
		tests_run++;
		if (errors != errors_at_start)
			tests_with_errors++;
		$display("Test %0d %s finished with %0d errors", tests_run, name,
			errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial
	begin
		int len;
		int pos;
		void'($urandom(SEED));
		S_AXIS_ARESETN     <= 1'b0;
		wr_queue_idx       <= '0;
		rd_queue_idx       <= '0;
		endless_mode       <= 1'b0;
		num_dma_symbol_raw <= CNT_WIDTH'(1);
		s_axis_tvalid      <= 1'b0;
		s_axis_tdata       <= '0;
		s_axis_tlast       <= 1'b0;
		acc_ask_data       <= 1'b0;
		repeat (4) @(posedge S_AXIS_ACLK);
		S_AXIS_ARESETN <= 1'b1;
		repeat (3) @(posedge S_AXIS_ACLK);
		report_test("reset state");

		for (int q = 0; q < NUM_TX_QUEUE; q++)
		begin
			len = 2 + int'($urandom_range(6));
			send_burst(q, len, 1'b0, 0, len);
		end
		drain_queues();
		report_test("queue steering");

		send_burst(1, 5, 1'b0, 0, 5);
		len = 3 + int'($urandom_range(5));
		send_burst(3, len, 1'b0, 0, len);
		drain_queues();
		report_test("length limit");

		send_burst(0, 10, 1'b0, 4, 4);
		len = 6 + int'($urandom_range(6));
		pos = 1 + int'($urandom_range(len - 2));
		send_burst(2, len, 1'b0, pos, pos);
		drain_queues();
		report_test("early tlast");

		fork
			send_burst(2, 4, 1'b1, DEPTH + 2, DEPTH + 2); // Short limit ignored in endless mode
			begin
				hold_full_and_pop(2, DEPTH);
				hold_full_and_pop(2, DEPTH + 1);
			end
		join
		drain_queues();
		report_test("endless mode and back-pressure");

		for (int q = 0; q < NUM_TX_QUEUE; q++)
		begin
			len = 3 + int'($urandom_range(3));
			send_burst(q, len, 1'b0, 0, len);
		end
		fork
			send_burst(2, 8, 1'b0, 0, 8); // Writes and pops on one queue together
			random_reads(40);
		join
		drain_queues();
		report_test("read order");

		$display("Tests run %0d, tests with errors %0d, check errors %0d",
			tests_run, tests_with_errors, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: tx_intf.f
design/tx_queue_pkg.sv
design/tx_dma_pkg.sv
design/tx_queue_fifo.sv
design/tx_intf_s_axis.sv
design/tx_intf.sv
tb/tb_tx_intf.sv

// File: run_sim.sh
#!/bin/sh
# Builds the transmit DMA intake testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_tx_intf \
	-f tx_intf.f \
	-o tb_tx_intf

sim_out=$(./obj_dir/tb_tx_intf)
printf '%s\n' "$sim_out"

# The run counts as good only if the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
